// ==== hw/pongGame_params.svh ====
`ifndef PONG_GAME_PARAMS_SVH
`define PONG_GAME_PARAMS_SVH

////////////////////////////////
// Memory port
`define ADDR_W 16
`define DATA_W 16

// Coordinates and counters
`define POS_W 8
`define QUEUE_PTR_W 4 // 16 entry wrap
`define SCORE_W 4

`define KEY_QUEUE_ADDR 0

////////////////////////////////
// Court, left edge and top wall at 0
`define COURT_RIGHT 63
`define COURT_BOTTOM 17

`define PADDLE_MIN 2
`define PADDLE_MAX 16
`define PADDLE_HOME 9
`define PADDLE_HALF 2

`define LEFT_SERVE_X 3
`define RIGHT_SERVE_X 60
`define LEFT_HIT_X 2
`define RIGHT_HIT_X 61

`define BALL_MAX_SPEED 5
`define SCORE_LIMIT 5

`endif

// ==== hw/pongBusPkg.sv ====
`include "pongGame_params.svh"

package pongBusPkg;

	// One memory access, strobed by enable
	typedef struct packed {
		logic enable;
		logic write;
		logic [`ADDR_W-1:0] address;
		logic [`DATA_W-1:0] writeData;
	} memRequest;

	typedef enum logic [1:0] {
		timerIrq    = 2'd0,
		keyboardIrq = 2'd1,
		idleIrq     = 2'd2,
		idleIrqAlt  = 2'd3 // Also idle
	} irqCode;

	// ASCII codes of the game keys
	typedef enum logic [7:0] {
		keyLeftUp    = 8'h77, // w
		keyLeftDown  = 8'h73, // s
		keyRightUp   = 8'h69, // i
		keyRightDown = 8'h6B, // k
		keySpace     = 8'h20,
		keyPause     = 8'h70, // p
		keyQuit      = 8'h71  // q
	} keyCode;

endpackage

// ==== hw/pongGamePkg.sv ====
`include "pongGame_params.svh"

package pongGamePkg;

	typedef enum logic [1:0] {
		ballHeldLeft,
		ballHeldRight,
		ballFlying
	} ballMode;

	typedef enum logic [1:0] {
		noWinner,
		leftWins,
		rightWins
	} winnerFlag;

	////////////////////////////////
	// Sequencer states
	typedef enum logic [4:0] {
		stReset,
		stWait,
		// Keyboard interrupt
		stKeyAck,
		stKeyLatch,
		stKeyLoad,
		stKeyWrite,
		// Timer interrupt
		stTimerAck,
		stDrainCheck,
		stPopAddr,
		stPopRead,
		stPopWait,
		stDecode,
		stTickCheck,
		stTick,
		stBallWait,
		// Endings
		stEnd,
		stQuitEnd,
		stSwitch,
		stRestartEnd
	} seqState;

	// What a display controller would read
	typedef struct packed {
		logic [`POS_W-1:0] ballX;
		logic [`POS_W-1:0] ballY;
		logic [`POS_W-1:0] leftPaddle;
		logic [`POS_W-1:0] rightPaddle;
		logic [`SCORE_W-1:0] scoreLeft;
		logic [`SCORE_W-1:0] scoreRight;
		winnerFlag winner;
		logic paused;
	} gameStatus;

endpackage

// ==== hw/keyQueue.sv ====
`timescale 1ns/100ps
`include "pongGame_params.svh"

module keyQueue (
	input  logic CLK,
	input  logic resetBall,
	input  logic clearGame,
	input  logic [7:0] kbdKey,
	input  logic [`DATA_W-1:0] memDataR,
	input  logic latchKey,
	input  logic loadPushAddr,
	input  logic loadPopAddr,
	input  logic pushKey,
	input  logic popKey,
	input  logic memStrobe,
	input  logic memWrite,
	output pongBusPkg::memRequest memBus,
	output logic queueEmpty,
	output pongBusPkg::keyCode poppedKey
);

	logic [`QUEUE_PTR_W-1:0] frontPtr;
	logic [`QUEUE_PTR_W-1:0] backPtr;
	logic [7:0] keyReg;
	logic [`ADDR_W-1:0] addrReg;
	logic [`DATA_W-1:0] dataReg;
	logic readPending; // Read data due this cycle
	logic [7:0] readBuf;

	////////////////////////////////
	// Queue pointers
	always_ff @(posedge CLK) begin
		if (resetBall || clearGame) begin
			frontPtr <= '0;
			backPtr <= '0;
		end else begin
			if (pushKey)
				backPtr <= backPtr + 1'b1;
			if (popKey)
				frontPtr <= frontPtr + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (resetBall)
			readPending <= 1'b0;
		else
			readPending <= memStrobe && !memWrite;
	end

	////////////////////////////////
	// Key latch, address and data registers
	always_ff @(posedge CLK) begin
		if (latchKey)
			keyReg <= kbdKey;
		if (loadPushAddr) begin
			addrReg <= `ADDR_W'(`KEY_QUEUE_ADDR + backPtr);
			dataReg <= {{(`DATA_W-8){1'b0}}, keyReg};
		end else if (loadPopAddr) begin
			addrReg <= `ADDR_W'(`KEY_QUEUE_ADDR + frontPtr);
		end
		if (readPending)
			readBuf <= memDataR[7:0]; // Key code in the low byte
	end

	assign memBus = '{enable: memStrobe, write: memWrite, address: addrReg, writeData: dataReg};
	assign queueEmpty = (frontPtr == backPtr);
	assign poppedKey = pongBusPkg::keyCode'(readBuf);

endmodule

// ==== hw/paddleTracker.sv ====
`timescale 1ns/100ps
`include "pongGame_params.svh"

module paddleTracker (
	input  logic CLK,
	input  logic resetBall,
	input  logic clearGame,
	input  logic up,
	input  logic down,
	output logic [`POS_W-1:0] position
);

	// Up lowers the row number, clamped to the court
	always_ff @(posedge CLK) begin
		if (resetBall || clearGame)
			position <= `PADDLE_HOME;
		else if (up && position > `PADDLE_MIN)
			position <= position - 1'b1;
		else if (down && position < `PADDLE_MAX)
			position <= position + 1'b1;
	end

endmodule

// ==== hw/ballTracker.sv ====
`timescale 1ns/100ps
`include "pongGame_params.svh"

module ballTracker (
	input  logic CLK,
	input  logic resetBall,
	input  logic clearGame,
	input  logic launch,
	input  logic tick,
	input  logic [`POS_W-1:0] leftPaddle,
	input  logic [`POS_W-1:0] rightPaddle,
	output logic [`POS_W-1:0] ballX,
	output logic [`POS_W-1:0] ballY,
	output logic ballDone,
	output logic pointLeft,
	output logic pointRight
);

	pongGamePkg::ballMode mode;
	logic dirLeft; // X decreasing
	logic dirUp;   // Y decreasing
	logic [2:0] speed;
	logic [2:0] stepCount;
	logic stepping;
	logic settling; // Last cycle of a tick

	logic [`POS_W-1:0] movedX;
	logic [`POS_W-1:0] movedY;
	logic [`POS_W-1:0] aheadX;
	logic [`POS_W-1:0] aheadY;
	logic stepEnd;
	logic hit;
	logic atEdge;
	logic atWall;
	logic serveLeft;
	logic serveRight;

	// Span from paddle - half inclusive to paddle + half exclusive
	function automatic logic inSpan(input logic [`POS_W-1:0] y, input logic [`POS_W-1:0] paddle);
		return (y >= paddle - `PADDLE_HALF) && (y < paddle + `PADDLE_HALF);
	endfunction

	////////////////////////////////
	// One step and its checks
	assign movedX = dirLeft ? ballX - 1'b1 : ballX + 1'b1;
	assign movedY = dirUp ? ballY - 1'b1 : ballY + 1'b1;
	assign aheadX = dirLeft ? movedX - 1'b1 : movedX + 1'b1;
	assign aheadY = dirUp ? movedY - 1'b1 : movedY + 1'b1;

	assign stepEnd = (stepCount >= speed);
	assign hit = (aheadX == `LEFT_HIT_X && inSpan(aheadY, leftPaddle)) ||
		(aheadX == `RIGHT_HIT_X && inSpan(aheadY, rightPaddle));
	assign atEdge = (movedX == 0) || (movedX == `COURT_RIGHT);
	assign atWall = (movedY == 0) || (movedY == `COURT_BOTTOM);

	// Serve when held, or after a point
	assign serveLeft = (tick && mode == pongGamePkg::ballHeldLeft) || (settling && ballX == 0);
	assign serveRight = (tick && mode == pongGamePkg::ballHeldRight) ||
		(settling && ballX == `COURT_RIGHT);

	assign pointRight = settling && (ballX == 0);
	assign pointLeft = settling && (ballX == `COURT_RIGHT);
	assign ballDone = settling;

	always_ff @(posedge CLK) begin
		if (resetBall || clearGame) begin
			mode <= pongGamePkg::ballHeldLeft;
			stepping <= 1'b0;
			settling <= 1'b0;
		end else begin
			if (serveLeft)
				mode <= pongGamePkg::ballHeldLeft;
			else if (serveRight)
				mode <= pongGamePkg::ballHeldRight;
			else if (launch)
				mode <= pongGamePkg::ballFlying;
			stepping <= (tick && mode == pongGamePkg::ballFlying) ||
				(stepping && !stepEnd && !hit && !atEdge && !atWall);
			settling <= (tick && mode != pongGamePkg::ballFlying) ||
				(stepping && (stepEnd || hit || atEdge || atWall));
		end
	end

	////////////////////////////////
	// Position, direction and speed
	always_ff @(posedge CLK) begin
		if (clearGame) begin
			ballX <= '0;
			ballY <= '0;
			dirLeft <= 1'b0;
			dirUp <= 1'b0;
			speed <= '0;
		end else if (serveLeft) begin
			ballX <= `LEFT_SERVE_X;
			ballY <= leftPaddle;
			dirLeft <= 1'b0; // Right and down
			dirUp <= 1'b0;
			speed <= 3'd1;
		end else if (serveRight) begin
			ballX <= `RIGHT_SERVE_X;
			ballY <= rightPaddle;
			dirLeft <= 1'b1; // Left and down
			dirUp <= 1'b0;
			speed <= 3'd1;
		end else if (stepping && !stepEnd) begin
			ballX <= movedX;
			ballY <= movedY;
			if (hit) begin
				dirLeft <= !dirLeft;
				if (speed < `BALL_MAX_SPEED)
					speed <= speed + 1'b1;
				if (atWall)
					dirUp <= !dirUp;
			end else if (!atEdge && atWall) begin
				dirUp <= !dirUp;
			end
		end
		if (tick)
			stepCount <= '0;
		else if (stepping && !stepEnd)
			stepCount <= stepCount + 1'b1;
	end

endmodule

// ==== hw/matchScore.sv ====
`timescale 1ns/100ps
`include "pongGame_params.svh"

module matchScore (
	input  logic CLK,
	input  logic resetBall,
	input  logic clearGame,
	input  logic pointLeft,
	input  logic pointRight,
	input  logic setPause,
	input  logic clearPause,
	output logic [`SCORE_W-1:0] scoreLeft,
	output logic [`SCORE_W-1:0] scoreRight,
	output pongGamePkg::winnerFlag winner,
	output logic paused
);

	always_ff @(posedge CLK) begin
		if (resetBall || clearGame) begin
			scoreLeft <= '0;
			scoreRight <= '0;
			winner <= pongGamePkg::noWinner;
			paused <= 1'b0;
		end else begin
			// First side to the limit keeps the title
			if (pointLeft) begin
				scoreLeft <= scoreLeft + 1'b1;
				if (scoreLeft == `SCORE_LIMIT - 1 && winner == pongGamePkg::noWinner)
					winner <= pongGamePkg::leftWins;
			end else if (pointRight) begin
				scoreRight <= scoreRight + 1'b1;
				if (scoreRight == `SCORE_LIMIT - 1 && winner == pongGamePkg::noWinner)
					winner <= pongGamePkg::rightWins;
			end
			if (setPause)
				paused <= 1'b1;
			else if (clearPause)
				paused <= 1'b0;
		end
	end

endmodule

// ==== hw/gameSequencer.sv ====
`timescale 1ns/100ps

module gameSequencer (
	input  logic CLK,
	input  logic resetBall,
	input  logic enable,
	input  pongBusPkg::irqCode intIrq,
	input  logic queueEmpty,
	input  pongBusPkg::keyCode poppedKey,
	input  logic ballDone,
	input  pongGamePkg::winnerFlag winner,
	input  logic paused,
	output logic intIack,
	output logic intIend,
	output logic switchRequest,
	output logic memStrobe,
	output logic memWrite,
	output logic clearGame,
	output logic latchKey,
	output logic loadPushAddr,
	output logic loadPopAddr,
	output logic pushKey,
	output logic popKey,
	output logic leftUp,
	output logic leftDown,
	output logic rightUp,
	output logic rightDown,
	output logic launch,
	output logic tick,
	output logic setPause,
	output logic clearPause
);

	pongGamePkg::seqState state;
	pongGamePkg::seqState nextState;
	logic frozen;

	assign frozen = (winner != pongGamePkg::noWinner) || paused;

	always_ff @(posedge CLK) begin
		if (resetBall || !enable)
			state <= pongGamePkg::stReset;
		else
			state <= nextState;
	end

	always_comb begin
		intIack = 1'b0;
		intIend = 1'b0;
		switchRequest = 1'b0;
		memStrobe = 1'b0;
		memWrite = 1'b0;
		clearGame = 1'b0;
		latchKey = 1'b0;
		loadPushAddr = 1'b0;
		loadPopAddr = 1'b0;
		pushKey = 1'b0;
		popKey = 1'b0;
		leftUp = 1'b0;
		leftDown = 1'b0;
		rightUp = 1'b0;
		rightDown = 1'b0;
		launch = 1'b0;
		tick = 1'b0;
		setPause = 1'b0;
		clearPause = 1'b0;
		nextState = state;

		case (state)
			pongGamePkg::stReset: begin
				clearGame = 1'b1;
				nextState = pongGamePkg::stWait;
			end
			pongGamePkg::stWait: begin
				if (intIrq == pongBusPkg::timerIrq)
					nextState = pongGamePkg::stTimerAck;
				else if (intIrq == pongBusPkg::keyboardIrq)
					nextState = pongGamePkg::stKeyAck;
			end

			////////////////////////////////
			// Keyboard interrupt, push one key
			pongGamePkg::stKeyAck: begin
				intIack = 1'b1;
				nextState = pongGamePkg::stKeyLatch;
			end
			pongGamePkg::stKeyLatch: begin
				latchKey = 1'b1;
				nextState = pongGamePkg::stKeyLoad;
			end
			pongGamePkg::stKeyLoad: begin
				loadPushAddr = 1'b1;
				nextState = pongGamePkg::stKeyWrite;
			end
			pongGamePkg::stKeyWrite: begin
				memStrobe = 1'b1;
				memWrite = 1'b1;
				pushKey = 1'b1;
				nextState = pongGamePkg::stEnd;
			end

			////////////////////////////////
			// Timer interrupt, drain then tick
			pongGamePkg::stTimerAck: begin
				intIack = 1'b1;
				nextState = pongGamePkg::stDrainCheck;
			end
			pongGamePkg::stDrainCheck: begin
				nextState = queueEmpty ? pongGamePkg::stTickCheck : pongGamePkg::stPopAddr;
			end
			pongGamePkg::stPopAddr: begin
				loadPopAddr = 1'b1;
				nextState = pongGamePkg::stPopRead;
			end
			pongGamePkg::stPopRead: begin
				memStrobe = 1'b1; // Read
				popKey = 1'b1;
				nextState = pongGamePkg::stPopWait;
			end
			pongGamePkg::stPopWait: begin
				nextState = pongGamePkg::stDecode; // Key lands in the read buffer
			end
			pongGamePkg::stDecode: begin
				nextState = pongGamePkg::stDrainCheck;
				if (!frozen) begin
					case (poppedKey)
						pongBusPkg::keyLeftUp: leftUp = 1'b1;
						pongBusPkg::keyLeftDown: leftDown = 1'b1;
						pongBusPkg::keyRightUp: rightUp = 1'b1;
						pongBusPkg::keyRightDown: rightDown = 1'b1;
						pongBusPkg::keySpace: launch = 1'b1;
						pongBusPkg::keyPause: setPause = 1'b1;
						default: ;
					endcase
				end else if (poppedKey == pongBusPkg::keyQuit) begin
					nextState = pongGamePkg::stQuitEnd;
				end else if (poppedKey == pongBusPkg::keySpace) begin
					if (winner == pongGamePkg::noWinner)
						clearPause = 1'b1; // Resume
					else
						nextState = pongGamePkg::stRestartEnd;
				end
			end
			pongGamePkg::stTickCheck: begin
				nextState = frozen ? pongGamePkg::stEnd : pongGamePkg::stTick;
			end
			pongGamePkg::stTick: begin
				tick = 1'b1;
				nextState = pongGamePkg::stBallWait;
			end
			pongGamePkg::stBallWait: begin
				if (ballDone)
					nextState = pongGamePkg::stEnd;
			end

			////////////////////////////////
			// End of interrupt
			pongGamePkg::stEnd: begin
				intIend = 1'b1;
				nextState = pongGamePkg::stWait;
			end
			pongGamePkg::stQuitEnd: begin
				intIend = 1'b1;
				nextState = pongGamePkg::stSwitch;
			end
			pongGamePkg::stSwitch: begin
				switchRequest = 1'b1; // Held until reset
			end
			pongGamePkg::stRestartEnd: begin
				intIend = 1'b1;
				nextState = pongGamePkg::stReset;
			end
			default: nextState = pongGamePkg::stReset;
		endcase
	end

endmodule

// ==== hw/pongTop.sv ====
`timescale 1ns/100ps
`include "pongGame_params.svh"

module pongTop (
	input  logic CLK,
	input  logic resetBall,
	input  logic enable,
	input  pongBusPkg::irqCode intIrq,
	input  logic [7:0] kbdKey,
	input  logic [`DATA_W-1:0] memDataR,
	output logic intIack,
	output logic intIend,
	output logic switchRequest,
	output pongBusPkg::memRequest memBus,
	output pongGamePkg::gameStatus status
);

	// Sequencer commands
	logic clearGame;
	logic latchKey;
	logic loadPushAddr;
	logic loadPopAddr;
	logic pushKey;
	logic popKey;
	logic memStrobe;
	logic memWrite;
	logic leftUp;
	logic leftDown;
	logic rightUp;
	logic rightDown;
	logic launch;
	logic tick;
	logic setPause;
	logic clearPause;

	// Unit results
	logic queueEmpty;
	pongBusPkg::keyCode poppedKey;
	logic ballDone;
	logic pointLeft;
	logic pointRight;
	logic [`POS_W-1:0] leftPos;
	logic [`POS_W-1:0] rightPos;
	logic [`POS_W-1:0] ballX;
	logic [`POS_W-1:0] ballY;
	logic [`SCORE_W-1:0] scoreLeft;
	logic [`SCORE_W-1:0] scoreRight;
	pongGamePkg::winnerFlag winner;
	logic paused;

	assign status = '{ballX: ballX, ballY: ballY, leftPaddle: leftPos, rightPaddle: rightPos,
		scoreLeft: scoreLeft, scoreRight: scoreRight, winner: winner, paused: paused};

	gameSequencer sequencer (
		.CLK(CLK), .resetBall(resetBall), .enable(enable), .intIrq(intIrq),
		.queueEmpty(queueEmpty), .poppedKey(poppedKey), .ballDone(ballDone),
		.winner(status.winner), .paused(status.paused),
		.intIack(intIack), .intIend(intIend), .switchRequest(switchRequest),
		.memStrobe(memStrobe), .memWrite(memWrite), .clearGame(clearGame),
		.latchKey(latchKey), .loadPushAddr(loadPushAddr), .loadPopAddr(loadPopAddr),
		.pushKey(pushKey), .popKey(popKey), .leftUp(leftUp), .leftDown(leftDown),
		.rightUp(rightUp), .rightDown(rightDown), .launch(launch), .tick(tick),
		.setPause(setPause), .clearPause(clearPause)
	);

	keyQueue queue (
		.CLK(CLK), .resetBall(resetBall), .clearGame(clearGame), .kbdKey(kbdKey),
		.memDataR(memDataR), .latchKey(latchKey), .loadPushAddr(loadPushAddr),
		.loadPopAddr(loadPopAddr), .pushKey(pushKey), .popKey(popKey),
		.memStrobe(memStrobe), .memWrite(memWrite), .memBus(memBus),
		.queueEmpty(queueEmpty), .poppedKey(poppedKey)
	);

	paddleTracker leftPaddle (
		.CLK(CLK), .resetBall(resetBall), .clearGame(clearGame),
		.up(leftUp), .down(leftDown), .position(leftPos)
	);

	paddleTracker rightPaddle (
		.CLK(CLK), .resetBall(resetBall), .clearGame(clearGame),
		.up(rightUp), .down(rightDown), .position(rightPos)
	);

	ballTracker ball (
		.CLK(CLK), .resetBall(resetBall), .clearGame(clearGame), .launch(launch),
		.tick(tick), .leftPaddle(leftPos), .rightPaddle(rightPos),
		.ballX(ballX), .ballY(ballY), .ballDone(ballDone),
		.pointLeft(pointLeft), .pointRight(pointRight)
	);

	matchScore score (
		.CLK(CLK), .resetBall(resetBall), .clearGame(clearGame),
		.pointLeft(pointLeft), .pointRight(pointRight),
		.setPause(setPause), .clearPause(clearPause),
		.scoreLeft(scoreLeft), .scoreRight(scoreRight), .winner(winner), .paused(paused)
	);

endmodule

// ==== verification/clockGen.sv ====
`timescale 1ns/100ps

module clockGen (
	output logic CLK,
	output logic resetBall
);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK; // 40 ns period
	end

	// Released just after the 16th rising edge
	initial begin
		resetBall = 1'b1;
		repeat (16) @(posedge CLK);
		#2 resetBall = 1'b0;
	end

endmodule

// ==== verification/pongModel.sv ====
`timescale 1ns/100ps
`include "pongGame_params.svh"

module pongModel (
	input  logic CLK,
	input  pongBusPkg::memRequest memBus,
	output logic [`DATA_W-1:0] memDataR
);

	////////////////////////////////
	// Memory, read data one cycle after the strobe
	logic [`DATA_W-1:0] mem [0:255];

	initial begin
		for (int a = 0; a < 256; a++)
			mem[a] = `DATA_W'(a * 257) ^ 16'h5AC3; // Both address bytes scrambled
		memDataR = '0;
	end

	always @(posedge CLK) begin
		if (memBus.enable && memBus.write)
			mem[memBus.address[7:0]] <= memBus.writeData;
		else if (memBus.enable)
			memDataR <= mem[memBus.address[7:0]]; // Holds until next read
	end

	////////////////////////////////
	// Expected game state
	int ballX;
	int ballY;
	int leftPaddle;
	int rightPaddle;
	int scoreLeft;
	int scoreRight;
	int speed;
	logic dirLeft;
	logic dirUp;
	logic paused;
	logic quitSeen;
	pongGamePkg::winnerFlag winner;
	pongGamePkg::ballMode mode;
	logic [7:0] keys [0:15];
	int frontPtr;
	int backPtr;

	task automatic clearGame();
		ballX = 0;
		ballY = 0;
		speed = 0;
		dirLeft = 1'b0;
		dirUp = 1'b0;
		mode = pongGamePkg::ballHeldLeft;
		leftPaddle = `PADDLE_HOME;
		rightPaddle = `PADDLE_HOME;
		scoreLeft = 0;
		scoreRight = 0;
		winner = pongGamePkg::noWinner;
		paused = 1'b0;
		quitSeen = 1'b0;
		frontPtr = 0;
		backPtr = 0;
	endtask

	task automatic pushKey(input logic [7:0] key);
		keys[backPtr] = key;
		backPtr = (backPtr + 1) % 16;
	endtask

	// Move only while the result stays on the court
	function automatic int paddleStep(input int pos, input int delta);
		if (pos + delta >= `PADDLE_MIN && pos + delta <= `PADDLE_MAX)
			return pos + delta;
		return pos;
	endfunction

	function automatic logic inSpan(input int y, input int paddle);
		return (y >= paddle - `PADDLE_HALF) && (y < paddle + `PADDLE_HALF);
	endfunction

	function automatic logic frozen();
		return (winner != pongGamePkg::noWinner) || paused;
	endfunction

	task automatic serve(input logic rightSide);
		ballX = rightSide ? `RIGHT_SERVE_X : `LEFT_SERVE_X;
		ballY = rightSide ? rightPaddle : leftPaddle;
		dirLeft = rightSide;
		dirUp = 1'b0; // Always serves downwards
		speed = 1;
		mode = rightSide ? pongGamePkg::ballHeldRight : pongGamePkg::ballHeldLeft;
	endtask

	task automatic awardPoint(input logic leftSide);
		if (leftSide) begin
			scoreLeft++;
			if (scoreLeft == `SCORE_LIMIT && winner == pongGamePkg::noWinner)
				winner = pongGamePkg::leftWins;
		end else begin
			scoreRight++;
			if (scoreRight == `SCORE_LIMIT && winner == pongGamePkg::noWinner)
				winner = pongGamePkg::rightWins;
		end
	endtask

	task automatic tickBall();
		int steps;
		int nextX;
		int nextY;
		logic stop;
		if (mode != pongGamePkg::ballFlying) begin
			serve(mode == pongGamePkg::ballHeldRight);
		end else begin
			steps = 0;
			stop = 1'b0;
			while (steps < speed && !stop) begin
				ballX = dirLeft ? ballX - 1 : ballX + 1;
				ballY = dirUp ? ballY - 1 : ballY + 1;
				nextX = dirLeft ? ballX - 1 : ballX + 1;
				nextY = dirUp ? ballY - 1 : ballY + 1;
				if ((nextX == `LEFT_HIT_X && inSpan(nextY, leftPaddle)) ||
					(nextX == `RIGHT_HIT_X && inSpan(nextY, rightPaddle))) begin
					dirLeft = !dirLeft;
					if (speed < `BALL_MAX_SPEED)
						speed++;
					if (ballY == 0 || ballY == `COURT_BOTTOM)
						dirUp = !dirUp;
					stop = 1'b1;
				end else if (ballX == 0 || ballX == `COURT_RIGHT) begin
					stop = 1'b1;
				end else if (ballY == 0 || ballY == `COURT_BOTTOM) begin
					dirUp = !dirUp; // Wall bounce
					stop = 1'b1;
				end
				steps++;
			end
			if (ballX == 0) begin
				awardPoint(1'b0);
				serve(1'b0);
			end else if (ballX == `COURT_RIGHT) begin
				awardPoint(1'b1);
				serve(1'b1);
			end
		end
	endtask

	// Drain every queued key, then move the ball
	task automatic timerTick();
		logic [7:0] key;
		logic stopped;
		stopped = 1'b0;
		while (frontPtr != backPtr && !stopped) begin
			key = keys[frontPtr];
			frontPtr = (frontPtr + 1) % 16;
			if (!frozen()) begin
				case (key)
					pongBusPkg::keyLeftUp: leftPaddle = paddleStep(leftPaddle, -1);
					pongBusPkg::keyLeftDown: leftPaddle = paddleStep(leftPaddle, 1);
					pongBusPkg::keyRightUp: rightPaddle = paddleStep(rightPaddle, -1);
					pongBusPkg::keyRightDown: rightPaddle = paddleStep(rightPaddle, 1);
					pongBusPkg::keySpace: mode = pongGamePkg::ballFlying;
					pongBusPkg::keyPause: paused = 1'b1;
					default: ;
				endcase
			end else if (key == pongBusPkg::keyQuit) begin
				quitSeen = 1'b1;
				stopped = 1'b1;
			end else if (key == pongBusPkg::keySpace) begin
				if (winner == pongGamePkg::noWinner) begin
					paused = 1'b0;
				end else begin
					clearGame(); // Restart drops the rest of the queue
					stopped = 1'b1;
				end
			end
		end
		if (!stopped && !frozen())
			tickBall();
	endtask

endmodule

// ==== verification/pongTb.sv ====
`timescale 1ns/100ps
`include "pongGame_params.svh"

module pongTb;

	logic CLK;
	logic resetBall;
	logic enable;
	pongBusPkg::irqCode intIrq;
	logic [7:0] kbdKey;
	logic [`DATA_W-1:0] memDataR;
	logic intIack;
	logic intIend;
	logic switchRequest;
	pongBusPkg::memRequest memBus;
	pongGamePkg::gameStatus status;

	integer seed = 96297;
	string testName;
	int testErrors;
	int errorCount;
	int testCount;
	int failedTests;
	logic hung; // Set by the first timeout

	clockGen clocks (.CLK(CLK), .resetBall(resetBall));

	pongTop UUT (
		.CLK(CLK), .resetBall(resetBall), .enable(enable), .intIrq(intIrq),
		.kbdKey(kbdKey), .memDataR(memDataR), .intIack(intIack), .intIend(intIend),
		.switchRequest(switchRequest), .memBus(memBus), .status(status)
	);

	pongModel model (.CLK(CLK), .memBus(memBus), .memDataR(memDataR));

	////////////////////////////////
	// Bookkeeping and checks
	task automatic startTest(input string name);
		testName = name;
		testErrors = 0;
	endtask

	task automatic finishTest();
		testCount++;
		if (testErrors == 0) begin
			$display("test %s passed", testName);
		end else begin
			$display("test %s failed with %0d errors", testName, testErrors);
			failedTests++;
		end
	endtask

	task automatic noteFailure();
		testErrors++;
		errorCount++;
	endtask

	task automatic checkValue(input string field, input int expected, input int actual);
		assert (actual == expected)
		else begin
			$display("error %s %s expected %0d actual %0d", testName, field, expected, actual);
			noteFailure();
		end
	endtask

	function automatic pongGamePkg::gameStatus expectedStatus();
		pongGamePkg::gameStatus s;
		s.ballX = `POS_W'(model.ballX);
		s.ballY = `POS_W'(model.ballY);
		s.leftPaddle = `POS_W'(model.leftPaddle);
		s.rightPaddle = `POS_W'(model.rightPaddle);
		s.scoreLeft = `SCORE_W'(model.scoreLeft);
		s.scoreRight = `SCORE_W'(model.scoreRight);
		s.winner = model.winner;
		s.paused = model.paused;
		return s;
	endfunction

	task automatic compareStatus(input pongGamePkg::gameStatus expected);
		checkValue("ballX", expected.ballX, status.ballX);
		checkValue("ballY", expected.ballY, status.ballY);
		checkValue("leftPaddle", expected.leftPaddle, status.leftPaddle);
		checkValue("rightPaddle", expected.rightPaddle, status.rightPaddle);
		checkValue("scoreLeft", expected.scoreLeft, status.scoreLeft);
		checkValue("scoreRight", expected.scoreRight, status.scoreRight);
		checkValue("winner", int'(expected.winner), int'(status.winner));
		checkValue("paused", expected.paused, status.paused);
	endtask

	////////////////////////////////
	// Interrupt driving
	task automatic nextCycle();
		@(posedge CLK);
		#2;
	endtask

	function automatic logic watched(input int which);
		case (which)
			0: return intIack;
			1: return intIend;
			default: return memBus.enable;
		endcase
	endfunction

	task automatic waitHigh(input int which, input string what);
		int cycles;
		cycles = 0;
		if (!hung) begin
			while (!watched(which) && cycles < 200) begin
				nextCycle();
				cycles++;
			end
			if (!watched(which)) begin
				$display("timeout in %s: no %s within 200 cycles", testName, what);
				hung = 1'b1;
				noteFailure();
			end
		end
	endtask

	// One keyboard interrupt with a check of the queue write
	task automatic keyPress(input logic [7:0] key);
		kbdKey = key;
		intIrq = pongBusPkg::keyboardIrq;
		waitHigh(0, "intIack for a key");
		intIrq = pongBusPkg::idleIrq;
		waitHigh(2, "queue write strobe");
		if (!hung) begin
			checkValue("write", 1, memBus.write);
			checkValue("address", `KEY_QUEUE_ADDR + model.backPtr, memBus.address);
			checkValue("writeData", key, memBus.writeData);
		end
		waitHigh(1, "intIend after a key");
		model.pushKey(key);
	endtask

	task automatic timerInterrupt();
		intIrq = pongBusPkg::timerIrq;
		waitHigh(0, "intIack for a timer interrupt");
		intIrq = pongBusPkg::idleIrq;
		waitHigh(1, "intIend for a timer interrupt");
		model.timerTick();
	endtask

	// First and count pick a subset of the keys w, i, s and k
	function automatic logic [7:0] paddleKey(input int first, input int count);
		logic [7:0] keySet [0:3];
		keySet[0] = pongBusPkg::keyLeftUp;
		keySet[1] = pongBusPkg::keyRightUp;
		keySet[2] = pongBusPkg::keyLeftDown;
		keySet[3] = pongBusPkg::keyRightDown;
		return keySet[first + $unsigned($random(seed)) % count];
	endfunction

	function automatic logic [7:0] otherKey();
		logic [7:0] key;
		key = 8'($random(seed));
		case (key)
			pongBusPkg::keyLeftUp, pongBusPkg::keyLeftDown, pongBusPkg::keyRightUp,
			pongBusPkg::keyRightDown, pongBusPkg::keySpace, pongBusPkg::keyPause,
			pongBusPkg::keyQuit: key = 8'h2E;
			default: ;
		endcase
		return key;
	endfunction

	////////////////////////////////
	// Test sequence
	initial begin
		int cycles;
		int rounds;
		pongGamePkg::gameStatus heldStatus;
		enable = 1'b1;
		intIrq = pongBusPkg::idleIrq;
		kbdKey = 8'h00;
		hung = 1'b0;
		errorCount = 0;
		testCount = 0;
		failedTests = 0;
		model.clearGame();

		startTest("afterReset");
		cycles = 0;
		while (resetBall !== 1'b0 && cycles < 200) begin
			@(negedge CLK);
			cycles++;
		end
		if (resetBall !== 1'b0) begin
			$display("timeout in %s: reset was never released", testName);
			hung = 1'b1;
			noteFailure();
		end
		nextCycle();
		nextCycle();
		compareStatus(expectedStatus());
		checkValue("intIack", 0, intIack);
		checkValue("intIend", 0, intIend);
		checkValue("switchRequest", 0, switchRequest);
		checkValue("memBus.enable", 0, memBus.enable);
		finishTest();

		startTest("keyQueue");
		for (int n = 0; n < 3; n++) begin
			for (int k = 0; k < 4; k++)
				keyPress(($random(seed) & 1) ? otherKey() : paddleKey(0, 4));
			timerInterrupt();
			compareStatus(expectedStatus());
		end
		finishTest();

		// Up keys first, then down keys, so both clamps are reached
		startTest("paddles");
		for (int n = 0; n < 45; n++) begin
			for (int k = 0; k < 3; k++) begin
				if (n < 15)
					keyPress(paddleKey(0, 2));
				else if (n < 30)
					keyPress(paddleKey(2, 2));
				else
					keyPress(($random(seed) % 4 == 0) ? otherKey() : paddleKey(0, 4));
			end
			timerInterrupt();
			compareStatus(expectedStatus());
		end
		finishTest();

		startTest("ballAndScore");
		rounds = 0;
		while (model.winner == pongGamePkg::noWinner && rounds < 2000 && !hung) begin
			if (model.mode != pongGamePkg::ballFlying)
				keyPress(pongBusPkg::keySpace);
			if ($random(seed) % 3 == 0)
				keyPress(paddleKey(0, 4));
			timerInterrupt();
			compareStatus(expectedStatus());
			rounds++;
		end
		assert (model.winner != pongGamePkg::noWinner)
		else begin
			$display("no side reached the score limit within 2000 ticks");
			noteFailure();
		end
		finishTest();

		startTest("pauseResume");
		keyPress(pongBusPkg::keySpace); // Restart after the win
		timerInterrupt();
		nextCycle();
		nextCycle();
		compareStatus(expectedStatus());
		timerInterrupt();
		keyPress(pongBusPkg::keySpace);
		for (int n = 0; n < 4; n++) begin
			timerInterrupt();
			compareStatus(expectedStatus());
		end
		keyPress(pongBusPkg::keyPause);
		timerInterrupt();
		heldStatus = expectedStatus();
		compareStatus(heldStatus);
		for (int n = 0; n < 4; n++) begin
			keyPress(paddleKey(0, 4));
			timerInterrupt();
			compareStatus(heldStatus);
		end
		keyPress(pongBusPkg::keySpace);
		timerInterrupt();
		compareStatus(expectedStatus());
		finishTest();

		startTest("quit");
		keyPress(pongBusPkg::keyPause);
		timerInterrupt();
		keyPress(pongBusPkg::keyQuit);
		keyPress(pongBusPkg::keyLeftUp); // Left in the queue
		timerInterrupt();
		compareStatus(expectedStatus());
		nextCycle();
		for (int n = 0; n < 20; n++) begin
			checkValue("switchRequest", model.quitSeen, switchRequest);
			nextCycle();
		end
		finishTest();

		$display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/pongBusPkg.sv
hw/pongGamePkg.sv
hw/keyQueue.sv
hw/paddleTracker.sv
hw/ballTracker.sv
hw/matchScore.sv
hw/gameSequencer.sv
hw/pongTop.sv
verification/clockGen.sv
verification/pongModel.sv
verification/pongTb.sv

// ==== Bender.yml ====
package:
  name: pong_game

export_include_dirs:
  - hw

sources:
  - hw/pongBusPkg.sv
  - hw/pongGamePkg.sv
  - hw/keyQueue.sv
  - hw/paddleTracker.sv
  - hw/ballTracker.sv
  - hw/matchScore.sv
  - hw/gameSequencer.sv
  - hw/pongTop.sv
  - target: simulation
    files:
      - verification/clockGen.sv
      - verification/pongModel.sv
      - verification/pongTb.sv
